//--- source/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// physical register file size and tag width
`define PHYS_REGS 64
`define PREG_BITS 6

// fetch queue entries
`define IQ_DEPTH 8

// reorder buffer size and index width
`define ROB_DEPTH 16
`define ROB_BITS 4

`endif

//--- source/rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

    // register-register layout also used for rd and the upper immediate bits
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // store layout with the split immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;
        s_fmt_t s;
    } inst_u;

    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // M extension funct7
    localparam logic [6:0] funct7_m = 7'b0000001;

    // value doubles as the bit index into rs_full
    typedef enum logic [2:0] {
        cls_alu = 3'd0,
        cls_mul = 3'd1,
        cls_div = 3'd2,
        cls_br  = 3'd3,
        cls_mem = 3'd4
    } rs_class_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } fetch_t;

    typedef struct packed {
        rs_class_t              rs_class;
        logic [31:0]            inst;
        logic [31:0]            pc;
        logic [31:0]            imm;
        logic [4:0]             rd_arch;
        logic [`PREG_BITS-1:0]  pd;
        logic [`PREG_BITS-1:0]  ps1;
        logic [`PREG_BITS-1:0]  ps2;
        logic                   ps1_ready;
        logic                   ps2_ready;
        logic [`ROB_BITS-1:0]   rob_idx;
        logic                   has_dest;
    } dispatch_t;

    // mapping that a ROB slot releases at commit
    typedef struct packed {
        logic                   has_dest;
        logic [`PREG_BITS-1:0]  old_pd;
    } rob_entry_t;

endpackage

//--- source/inst_queue.sv
`include "rename_macros.svh"

module inst_queue import rename_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  fetch_t  in_data,
    input  logic    in_valid,
    output logic    in_ready,
    output fetch_t  head,
    output logic    head_valid,
    input  logic    pop
);

    localparam int unsigned PTR_BITS = $clog2(`IQ_DEPTH);
    localparam int unsigned CNT_BITS = PTR_BITS + 1;

    fetch_t                 slots [`IQ_DEPTH];
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [CNT_BITS-1:0]    count;
    logic                   push;

    assign in_ready   = (count != CNT_BITS'(`IQ_DEPTH));
    assign head_valid = (count != '0);
    assign head       = slots[rd_ptr];
    assign push       = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in_data;
        end
    end

    // dispatch must only take a valid head
    pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> head_valid)
        else $error("inst_queue: pop while empty");

endmodule

//--- source/free_list.sv
`include "rename_macros.svh"

module free_list (
    input  logic                    clk,
    input  logic                    rst,
    output logic [`PREG_BITS-1:0]   head_preg,
    output logic                    empty,
    input  logic                    pop,
    input  logic                    push,
    input  logic [`PREG_BITS-1:0]   push_preg
);

    // architectural registers hold the low half at reset
    localparam int unsigned ARCH_REGS = 32;
    localparam int unsigned FL_DEPTH  = `PHYS_REGS - ARCH_REGS;
    localparam int unsigned PTR_BITS  = $clog2(FL_DEPTH);
    localparam int unsigned CNT_BITS  = PTR_BITS + 1;

    logic [`PREG_BITS-1:0]  slots [FL_DEPTH];
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [CNT_BITS-1:0]    count;

    assign empty     = (count == '0);
    assign head_preg = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            // list starts full with 32..63 in ascending order
            for (int i = 0; i < FL_DEPTH; i++) begin
                slots[i] <= `PREG_BITS'(ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= CNT_BITS'(FL_DEPTH);
        end else begin
            if (push) begin
                slots[wr_ptr] <= push_preg;
                wr_ptr        <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("free_list: pop while empty");

    // commit can never return more registers than were handed out
    push_not_full: assert property (@(posedge clk) disable iff (rst)
        push && !pop |-> count != CNT_BITS'(FL_DEPTH))
        else $error("free_list: push while full");

    // p0 is the fixed home of x0
    no_push_p0: assert property (@(posedge clk) disable iff (rst) push |-> push_preg != '0)
        else $error("free_list: physical 0 returned");

endmodule

//--- source/reg_alias_table.sv
`include "rename_macros.svh"

module reg_alias_table (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [`PREG_BITS-1:0]   ps1,
    output logic [`PREG_BITS-1:0]   ps2,
    output logic                    ps1_ready,
    output logic                    ps2_ready,
    input  logic                    ren_we,
    input  logic [4:0]              ren_rd,
    input  logic [`PREG_BITS-1:0]   ren_pd,
    output logic [`PREG_BITS-1:0]   old_pd,
    input  logic                    wb_valid,
    input  logic [`PREG_BITS-1:0]   wb_preg
);

    logic [`PREG_BITS-1:0]  map [32];
    logic [`PHYS_REGS-1:0]  ready;

    assign ps1    = map[rs1];
    assign ps2    = map[rs2];
    assign old_pd = map[ren_rd];

    // same-cycle writeback counts as ready
    assign ps1_ready = ready[ps1] || (wb_valid && (wb_preg == ps1));
    assign ps2_ready = ready[ps2] || (wb_valid && (wb_preg == ps2));

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity mapping with every register holding committed state
            for (int i = 0; i < 32; i++) begin
                map[i] <= `PREG_BITS'(i);
            end
            ready <= '1;
        end else begin
            if (wb_valid) begin
                ready[wb_preg] <= 1'b1;
            end
            // rename comes last so it wins over a writeback to the same tag
            if (ren_we) begin
                map[ren_rd]   <= ren_pd;
                ready[ren_pd] <= 1'b0;
            end
        end
    end

    // x0 must stay on p0 for the always-ready rule
    no_rename_x0: assert property (@(posedge clk) disable iff (rst) ren_we |-> ren_rd != '0)
        else $error("reg_alias_table: rename of x0");

endmodule

//--- source/rob_tracker.sv
`include "rename_macros.svh"

module rob_tracker import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc,
    input  logic [`PREG_BITS-1:0]   alloc_old_pd,
    input  logic                    alloc_has_dest,
    output logic [`ROB_BITS-1:0]    rob_idx,
    output logic                    full,
    input  logic                    commit_valid,
    output logic                    commit_ready,
    output logic                    free_valid,
    output logic [`PREG_BITS-1:0]   free_preg
);

    rob_entry_t             ring [`ROB_DEPTH];
    logic [`ROB_BITS-1:0]   head_ptr;
    logic [`ROB_BITS-1:0]   tail_ptr;
    logic [`ROB_BITS:0]     count;
    logic                   commit;

    assign rob_idx      = tail_ptr;
    assign full         = (count == (`ROB_BITS+1)'(`ROB_DEPTH));
    assign commit_ready = (count != '0);
    assign commit       = commit_valid && commit_ready;

    // old mapping goes back to the free list on the commit edge
    assign free_valid = commit && ring[head_ptr].has_dest;
    assign free_preg  = ring[head_ptr].old_pd;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (alloc) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (commit) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({alloc, commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ring[tail_ptr] <= '{has_dest: alloc_has_dest, old_pd: alloc_old_pd};
        end
    end

    alloc_not_full: assert property (@(posedge clk) disable iff (rst) alloc |-> !full)
        else $error("rob_tracker: allocation while full");

endmodule

//--- source/rename_dispatch.sv
`include "rename_macros.svh"

module rename_dispatch import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  fetch_t                  head,
    input  logic                    head_valid,
    output logic                    pop,
    input  logic [4:0]              rs_full,
    input  logic [`PREG_BITS-1:0]   fl_preg,
    input  logic                    fl_empty,
    output logic                    fl_pop,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    input  logic [`PREG_BITS-1:0]   ps1,
    input  logic [`PREG_BITS-1:0]   ps2,
    input  logic                    ps1_ready,
    input  logic                    ps2_ready,
    output logic                    ren_we,
    output logic [4:0]              ren_rd,
    output logic [`PREG_BITS-1:0]   ren_pd,
    input  logic [`PREG_BITS-1:0]   old_pd,
    input  logic                    rob_full,
    input  logic [`ROB_BITS-1:0]    rob_idx,
    output logic                    rob_alloc,
    output logic [`PREG_BITS-1:0]   alloc_old_pd,
    output logic                    alloc_has_dest,
    output dispatch_t               dispatch,
    output logic                    dispatch_valid
);

    inst_u      word;
    logic [6:0] opcode;
    rs_class_t  cls;
    logic [31:0] imm;
    logic       has_dest;
    logic       reads_rs1;
    logic       reads_rs2;
    logic       take;

    assign word   = head.inst;
    assign opcode = word.r.opcode;

    // reservation station class
    always_comb begin
        cls = cls_alu;
        if (opcode == op_reg && word.r.funct7 == funct7_m) begin
            cls = word.r.funct3[2] ? cls_div : cls_mul;
        end else if (opcode inside {op_jal, op_jalr, op_br}) begin
            cls = cls_br;
        end else if (opcode inside {op_load, op_store}) begin
            cls = cls_mem;
        end
    end

    // sign-extended immediate per format
    always_comb begin
        case (opcode)
            op_lui, op_auipc: begin
                imm = {word.r.funct7, word.r.rs2, word.r.rs1, word.r.funct3, 12'b0};
            end
            op_jal: begin
                imm = {{12{word.r.funct7[6]}}, word.r.rs1, word.r.funct3, word.r.rs2[0],
                       word.r.funct7[5:0], word.r.rs2[4:1], 1'b0};
            end
            op_jalr, op_load, op_imm: begin
                imm = {{20{word.r.funct7[6]}}, word.r.funct7, word.r.rs2};
            end
            op_br: begin
                imm = {{20{word.s.imm_hi[6]}}, word.s.imm_lo[0], word.s.imm_hi[5:0],
                       word.s.imm_lo[4:1], 1'b0};
            end
            op_store: begin
                imm = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
            end
            default: imm = '0;
        endcase
    end

    assign has_dest  = !(opcode inside {op_br, op_store}) && (word.r.rd != '0);
    assign reads_rs1 = opcode inside {op_jalr, op_br, op_load, op_store, op_imm, op_reg};
    assign reads_rs2 = opcode inside {op_br, op_store, op_reg};

    // unused sources read the always ready x0
    assign rs1 = reads_rs1 ? word.r.rs1 : 5'd0;
    assign rs2 = reads_rs2 ? word.r.rs2 : 5'd0;

    // the head waits for the rob, its station and a free tag
    assign take = head_valid && !rob_full && !rs_full[cls] && (!has_dest || !fl_empty);

    assign pop            = take;
    assign fl_pop         = take && has_dest;
    assign ren_we         = take && has_dest;
    assign ren_rd         = word.r.rd;
    assign ren_pd         = fl_preg;
    assign rob_alloc      = take;
    assign alloc_old_pd   = old_pd;
    assign alloc_has_dest = has_dest;

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= take;
        end
    end

    // packet payload loads only on a take
    always_ff @(posedge clk) begin
        if (take) begin
            dispatch.rs_class  <= cls;
            dispatch.inst      <= head.inst;
            dispatch.pc        <= head.pc;
            dispatch.imm       <= imm;
            dispatch.rd_arch   <= has_dest ? word.r.rd : 5'd0;
            dispatch.pd        <= has_dest ? fl_preg : '0;
            dispatch.ps1       <= ps1;
            dispatch.ps2       <= ps2;
            dispatch.ps1_ready <= ps1_ready;
            dispatch.ps2_ready <= ps2_ready;
            dispatch.rob_idx   <= rob_idx;
            dispatch.has_dest  <= has_dest;
        end
    end

endmodule

//--- source/rename_top.sv
`include "rename_macros.svh"

module rename_top import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  fetch_t                  fetch,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    input  logic [4:0]              rs_full,
    input  logic                    wb_valid,
    input  logic [`PREG_BITS-1:0]   wb_preg,
    input  logic                    commit_valid,
    output logic                    commit_ready,
    output dispatch_t               dispatch,
    output logic                    dispatch_valid
);

    fetch_t                 iq_head;
    logic                   iq_valid;
    logic                   iq_pop;
    logic [`PREG_BITS-1:0]  fl_preg;
    logic                   fl_empty;
    logic                   fl_pop;
    logic                   fl_push;
    logic [`PREG_BITS-1:0]  fl_push_preg;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [`PREG_BITS-1:0]  ps1;
    logic [`PREG_BITS-1:0]  ps2;
    logic                   ps1_ready;
    logic                   ps2_ready;
    logic                   ren_we;
    logic [4:0]             ren_rd;
    logic [`PREG_BITS-1:0]  ren_pd;
    logic [`PREG_BITS-1:0]  old_pd;
    logic                   rob_full;
    logic [`ROB_BITS-1:0]   rob_idx;
    logic                   rob_alloc;
    logic [`PREG_BITS-1:0]  alloc_old_pd;
    logic                   alloc_has_dest;

    inst_queue i_inst_queue (
        .clk(clk), .rst(rst),
        .in_data(fetch), .in_valid(fetch_valid), .in_ready(fetch_ready),
        .head(iq_head), .head_valid(iq_valid), .pop(iq_pop)
    );

    free_list i_free_list (
        .clk(clk), .rst(rst),
        .head_preg(fl_preg), .empty(fl_empty), .pop(fl_pop),
        .push(fl_push), .push_preg(fl_push_preg)
    );

    reg_alias_table i_rat (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2), .ps1(ps1), .ps2(ps2),
        .ps1_ready(ps1_ready), .ps2_ready(ps2_ready),
        .ren_we(ren_we), .ren_rd(ren_rd), .ren_pd(ren_pd), .old_pd(old_pd),
        .wb_valid(wb_valid), .wb_preg(wb_preg)
    );

    // committed entries return their old mapping to the free list
    rob_tracker i_rob_tracker (
        .clk(clk), .rst(rst),
        .alloc(rob_alloc), .alloc_old_pd(alloc_old_pd), .alloc_has_dest(alloc_has_dest),
        .rob_idx(rob_idx), .full(rob_full),
        .commit_valid(commit_valid), .commit_ready(commit_ready),
        .free_valid(fl_push), .free_preg(fl_push_preg)
    );

    rename_dispatch i_rename_dispatch (
        .clk(clk), .rst(rst),
        .head(iq_head), .head_valid(iq_valid), .pop(iq_pop), .rs_full(rs_full),
        .fl_preg(fl_preg), .fl_empty(fl_empty), .fl_pop(fl_pop),
        .rs1(rs1), .rs2(rs2), .ps1(ps1), .ps2(ps2),
        .ps1_ready(ps1_ready), .ps2_ready(ps2_ready),
        .ren_we(ren_we), .ren_rd(ren_rd), .ren_pd(ren_pd), .old_pd(old_pd),
        .rob_full(rob_full), .rob_idx(rob_idx), .rob_alloc(rob_alloc),
        .alloc_old_pd(alloc_old_pd), .alloc_has_dest(alloc_has_dest),
        .dispatch(dispatch), .dispatch_valid(dispatch_valid)
    );

endmodule

//--- tests/rename_checker.sv
`include "rename_macros.svh"

module rename_checker import rename_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  fetch_t          fetch,
    input  logic            fetch_valid,
    input  logic            fetch_ready,
    input  dispatch_t       dispatch,
    input  logic            dispatch_valid,
    input  logic [4:0]      rs_full,
    input  dispatch_t       exp_rec,
    input  logic            exp_valid,
    input  logic [127:0]    exp_name,
    input  logic            done,
    output int              errors,
    output int              pending
);

    dispatch_t      exp_q [$];
    logic [127:0]   name_q [$];
    // accepted fetches in program order
    fetch_t         fetch_q [$];
    // station fullness seen on the edge that took the instruction
    logic [4:0]     take_mask;
    logic           reported;
    // rob slots are handed out in dispatch order from 0
    int             dispatched;

    task automatic compare_field(input logic [127:0] name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %0s %0s expected %h actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    initial begin
        errors     = 0;
        pending    = 0;
        take_mask  = '0;
        reported   = 1'b0;
        dispatched = 0;
    end

    // registered outputs still hold the ending cycle at the posedge
    always @(posedge clk) begin : check_dispatch
        dispatch_t      want;
        logic [127:0]   name;
        fetch_t         fetched;
        logic           have_fetch;
        if (!rst) begin
            if (fetch_valid && fetch_ready) begin
                fetch_q.push_back(fetch);
            end
            if (exp_valid) begin
                exp_q.push_back(exp_rec);
                name_q.push_back(exp_name);
            end
            if (dispatch_valid) begin
                have_fetch = (fetch_q.size() != 0);
                if (have_fetch) begin
                    fetched = fetch_q.pop_front();
                end
                if (take_mask[dispatch.rs_class]) begin
                    $display("pc %h was dispatched while its reservation station was full",
                             dispatch.pc);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("pc %h was dispatched with no expected record left", dispatch.pc);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    name = name_q.pop_front();
                    compare_field(name, "class", 32'(want.rs_class), 32'(dispatch.rs_class));
                    compare_field(name, "pd", 32'(want.pd), 32'(dispatch.pd));
                    compare_field(name, "ps1", 32'(want.ps1), 32'(dispatch.ps1));
                    compare_field(name, "ps2", 32'(want.ps2), 32'(dispatch.ps2));
                    compare_field(name, "ps1_ready", 32'(want.ps1_ready),
                                  32'(dispatch.ps1_ready));
                    compare_field(name, "ps2_ready", 32'(want.ps2_ready),
                                  32'(dispatch.ps2_ready));
                    compare_field(name, "imm", want.imm, dispatch.imm);
                    compare_field(name, "has_dest", 32'(want.pd != '0),
                                  32'(dispatch.has_dest));
                    compare_field(name, "rob_idx", 32'(dispatched % `ROB_DEPTH),
                                  32'(dispatch.rob_idx));
                    if (!have_fetch) begin
                        $display("%0s dispatched pc %h that was never fetched",
                                 name, dispatch.pc);
                        errors++;
                    end else begin
                        compare_field(name, "pc", fetched.pc, dispatch.pc);
                        compare_field(name, "inst", fetched.inst, dispatch.inst);
                        if (want.pd != '0) begin
                            compare_field(name, "rd_arch", 32'(fetched.inst[11:7]),
                                          32'(dispatch.rd_arch));
                        end
                    end
                end
                dispatched++;
            end
            if (done && !reported) begin
                if (exp_q.size() != 0) begin
                    $display("%0d expected dispatches never arrived", exp_q.size());
                    errors += exp_q.size();
                end
                reported = 1'b1;
            end
        end
        take_mask = rs_full;
        pending   = exp_q.size();
    end

endmodule

//--- tests/tb_rename.sv
`include "rename_macros.svh"

module tb_rename import rename_pkg::*; ();

    // cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic                   clk;
    logic                   rst;
    fetch_t                 fetch;
    logic                   fetch_valid;
    logic                   fetch_ready;
    logic [4:0]             rs_full;
    logic                   wb_valid;
    logic [`PREG_BITS-1:0]  wb_preg;
    logic                   commit_valid;
    logic                   commit_ready;
    dispatch_t              dispatch;
    logic                   dispatch_valid;
    dispatch_t              exp_rec;
    logic                   exp_valid;
    logic [127:0]           exp_name;
    logic                   done;
    int                     check_errors;
    int                     pending;
    int                     tb_errors;

    rename_top i_rename_top (
        .clk(clk), .rst(rst),
        .fetch(fetch), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .rs_full(rs_full), .wb_valid(wb_valid), .wb_preg(wb_preg),
        .commit_valid(commit_valid), .commit_ready(commit_ready),
        .dispatch(dispatch), .dispatch_valid(dispatch_valid)
    );

    rename_checker i_checker (
        .clk(clk), .rst(rst),
        .fetch(fetch), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .dispatch(dispatch), .dispatch_valid(dispatch_valid), .rs_full(rs_full),
        .exp_rec(exp_rec), .exp_valid(exp_valid), .exp_name(exp_name),
        .done(done), .errors(check_errors), .pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one-cycle inputs drop back to idle at every falling edge
    task automatic clear_pulses();
        fetch_valid  = 1'b0;
        commit_valid = 1'b0;
        wb_valid     = 1'b0;
        exp_valid    = 1'b0;
    endtask

    task automatic fetch_inst(input logic [31:0] word, input logic [31:0] pc);
        int waited;
        waited = 0;
        @(negedge clk);
        clear_pulses();
        fetch.inst  = word;
        fetch.pc    = pc;
        fetch_valid = 1'b1;
        while (!fetch_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!fetch_ready) begin
            $display("timeout: the queue never accepted the instruction at pc %h", pc);
            tb_errors++;
        end
        @(posedge clk);
    endtask

    task automatic commit_one();
        int waited;
        waited = 0;
        @(negedge clk);
        clear_pulses();
        commit_valid = 1'b1;
        while (!commit_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!commit_ready) begin
            $display("timeout: the ROB stayed empty when a commit was due");
            tb_errors++;
        end
        @(posedge clk);
    endtask

    task automatic write_back(input int preg);
        @(negedge clk);
        clear_pulses();
        wb_valid = 1'b1;
        wb_preg  = `PREG_BITS'(preg);
        @(posedge clk);
    endtask

    task automatic set_full_mask(input logic [4:0] mask);
        @(negedge clk);
        clear_pulses();
        rs_full = mask;
        @(posedge clk);
    endtask

    task automatic idle(input int cycles);
        @(negedge clk);
        clear_pulses();
        repeat (cycles) @(posedge clk);
    endtask

    task automatic send_expect(input logic [127:0] name, input dispatch_t rec);
        @(negedge clk);
        clear_pulses();
        exp_name  = name;
        exp_rec   = rec;
        exp_valid = 1'b1;
        @(posedge clk);
    endtask

    initial begin
        int              fd;
        int              code;
        int              count;
        int              cls;
        int              pd;
        int              ps1;
        int              ps2;
        int              r1;
        int              r2;
        int              waited;
        string           line;
        logic [7:0]      cmd;
        logic [31:0]     word;
        logic [31:0]     pc;
        logic [31:0]     imm;
        logic [4:0]      mask;
        logic [127:0]    name;
        dispatch_t       rec;

        fetch        = '0;
        fetch_valid  = 1'b0;
        rs_full      = '0;
        wb_valid     = 1'b0;
        wb_preg      = '0;
        commit_valid = 1'b0;
        exp_rec      = '0;
        exp_valid    = 1'b0;
        exp_name     = '0;
        done         = 1'b0;
        tb_errors    = 0;
        rst          = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("tests/rename_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tests/rename_trace.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && $sscanf(line, "%c", cmd) == 1) begin
                    case (cmd)
                        "F": begin
                            code = $sscanf(line, "%c %d %h %h", cmd, count, word, pc);
                            for (int i = 0; i < count; i++) begin
                                fetch_inst(word, pc + 32'(4 * i));
                            end
                        end
                        "C": begin
                            code = $sscanf(line, "%c %d", cmd, count);
                            repeat (count) commit_one();
                        end
                        "W": begin
                            code = $sscanf(line, "%c %d", cmd, pd);
                            write_back(pd);
                        end
                        "R": begin
                            code = $sscanf(line, "%c %h", cmd, mask);
                            set_full_mask(mask);
                        end
                        "N": begin
                            code = $sscanf(line, "%c %d", cmd, count);
                            idle(count);
                        end
                        "E": begin
                            code = $sscanf(line, "%c %s %d %d %d %d %d %d %d %h", cmd, name,
                                           count, cls, pd, ps1, ps2, r1, r2, imm);
                            rec           = '0;
                            rec.rs_class  = rs_class_t'(cls);
                            rec.ps1       = `PREG_BITS'(ps1);
                            rec.ps2       = `PREG_BITS'(ps2);
                            rec.ps1_ready = r1[0];
                            rec.ps2_ready = r2[0];
                            rec.imm       = imm;
                            // repeated records take consecutive free registers
                            for (int i = 0; i < count; i++) begin
                                rec.pd = (pd == 0) ? '0 : `PREG_BITS'(pd + i);
                                send_expect(name, rec);
                            end
                        end
                        "#", " ", "\n", "\r": begin
                        end
                        default: begin
                            $display("unknown command in the trace file: %0s", line);
                            tb_errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        // let the last dispatches drain
        waited = 0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("timeout: %0d expected dispatches never came out of the DUT", pending);
            tb_errors++;
        end
        @(negedge clk);
        clear_pulses();
        done = 1'b1;
        @(posedge clk);
        @(negedge clk);
        $display("errors: %0d in dispatch checks, %0d in the testbench", check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/rename_trace.txt
# F count inst pc | C count | W preg | R rs_full (hex) | N cycles
# E test count class pd ps1 ps2 ps1_ready ps2_ready imm (hex), pd steps by one per copy
E classify 1 1 32 1 2 1 1 00000000
E classify 1 2 33 32 1 0 1 00000000
E classify 1 4 34 2 0 1 1 fffffffc
E no_dest 1 4 0 33 34 0 0 fffffff8
E no_dest 1 3 0 1 2 1 1 00000010
E classify 1 0 35 0 0 1 1 12345000
E no_dest 1 0 0 1 0 1 1 00000005
F 1 022081b3 00001000
F 1 0211c233 00001004
F 1 ffc12283 00001008
F 1 fe522c23 0000100c
F 1 00208863 00001010
F 1 12345337 00001014
F 1 00508013 00001018
W 32
E ready 1 0 36 32 0 1 1 ffffffff
E ready 1 0 37 0 33 1 0 00000000
F 1 fff18393 0000101c
F 1 00400433 00001020
R 10
E backpressure 1 4 38 1 0 1 1 00000000
E backpressure 1 0 39 38 0 0 1 00000001
E backpressure 1 0 40 0 0 1 1 00000002
F 1 0000a483 00001024
F 1 00148513 00001028
F 1 00200593 0000102c
N 6
R 0
C 12
E recycle 7 0 41 0 0 1 1 00000007
F 7 00700613 00001030
C 7
E recycle 16 0 48 0 0 1 1 00000007
F 16 00700613 0000104c
E recycle 1 0 3 0 0 1 1 00001000
F 1 00001697 0000108c
N 4
C 1
N 4

//--- compile.f
+incdir+source
source/rename_pkg.sv
source/inst_queue.sv
source/free_list.sv
source/reg_alias_table.sv
source/rob_tracker.sv
source/rename_dispatch.sv
source/rename_top.sv
tests/rename_checker.sv
tests/tb_rename.sv
